//--- core_ctrl.f
source/core_ctrl_pkg.sv
source/int_controller.sv
source/csr_regs.sv
source/cycle_counter.sv
source/ctrl_fsm.sv
source/core_ctrl_top.sv
dv/tb_clk_gen.sv
dv/tb_core_ctrl.sv

//--- Bender.yml
package:
  name: core_ctrl

sources:
  # RTL in compile order
  - source/core_ctrl_pkg.sv
  - source/int_controller.sv
  - source/csr_regs.sv
  - source/cycle_counter.sv
  - source/ctrl_fsm.sv
  - source/core_ctrl_top.sv

  # Testbench
  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/tb_core_ctrl.sv

//--- dv/tb_core_ctrl.sv
`timescale 1ns/1ps

module tb_core_ctrl;

  import core_ctrl_pkg::*;

  // Cycle limits for every polling loop
  localparam int RESET_TIMEOUT = 20;
  localparam int ACK_TIMEOUT   = 10;
  localparam int SLEEP_TIMEOUT = 10;
  localparam int MIP_TIMEOUT   = 8;
  localparam int QUIET_CYCLES  = 20;

  // Lines 3, 7 and 11 only
  localparam irq_vec_t LOW_LINES = 32'h0000_0888;

  logic        clk;
  logic        arst_n;
  logic        fetch_enable;
  logic        wfi;
  irq_vec_t    irq;
  logic        csr_we;
  csr_addr_t   csr_addr;
  csr_data_t   csr_wdata;
  csr_data_t   csr_rdata;
  logic        irq_ack;
  irq_id_t     irq_id;
  logic        core_sleep;
  logic [31:0] lfsr_state;

  tb_clk_gen clk_gen0 (
    .clk_o    ( clk    ),
    .arst_n_o ( arst_n )
  );

  core_ctrl_top dut0 (
    .clk_i          ( clk          ),
    .arst_n_i       ( arst_n       ),
    .fetch_enable_i ( fetch_enable ),
    .wfi_i          ( wfi          ),
    .irq_i          ( irq          ),
    .csr_we_i       ( csr_we       ),
    .csr_addr_i     ( csr_addr     ),
    .csr_wdata_i    ( csr_wdata    ),
    .csr_rdata_o    ( csr_rdata    ),
    .irq_ack_o      ( irq_ack      ),
    .irq_id_o       ( irq_id       ),
    .core_sleep_o   ( core_sleep   )
  );

  ////////////////////////////////////////////////////////////
  // Random numbers and reference model
  ////////////////////////////////////////////////////////////

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  // One LFSR step per bit
  function automatic logic [31:0] random_word();
    logic [31:0] w;
    w = '0;
    for (int i = 0; i < 32; i++) begin
      w          = {w[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
    return w;
  endfunction

  // Fast lines from the top then external, software and timer
  function automatic irq_id_t expected_id(input irq_vec_t pend);
    for (int i = 31; i >= 16; i--) begin
      if (pend[i]) begin
        return irq_id_t'(i);
      end
    end
    if (pend[11]) begin
      return 5'd11;
    end
    if (pend[3]) begin
      return 5'd3;
    end
    if (pend[7]) begin
      return 5'd7;
    end
    return '0;
  endfunction

  ////////////////////////////////////////////////////////////
  // Error handling and compare tasks
  ////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("test failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out at %0d ns while waiting for %s", $time, what);
    abort_run();
  endtask

  task automatic compare_csr(input string msg, input csr_data_t got, input csr_data_t exp);
    if (got !== exp) begin
      $display("FAILED at %0d ns: %s, got %h, expected %h", $time, msg, got, exp);
      abort_run();
    end
  endtask

  task automatic compare_irq_id(input string msg, input irq_id_t got, input irq_id_t exp);
    if (got !== exp) begin
      $display("FAILED at %0d ns: %s, got %0d, expected %0d", $time, msg, got, exp);
      abort_run();
    end
  endtask

  // Single-bit status outputs
  task automatic compare_level(input string msg, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED at %0d ns: %s, got %b, expected %b", $time, msg, got, exp);
      abort_run();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Bus and wait helpers
  ////////////////////////////////////////////////////////////

  // Write lands on the second edge
  task automatic csr_write(input csr_addr_t addr, input csr_data_t data);
    @(posedge clk);
    csr_we    <= 1'b1;
    csr_addr  <= addr;
    csr_wdata <= data;
    @(posedge clk);
    csr_we    <= 1'b0;
  endtask

  // Combinational read sampled mid-cycle
  task automatic csr_read(input csr_addr_t addr, output csr_data_t data);
    @(posedge clk);
    csr_we   <= 1'b0;
    csr_addr <= addr;
    @(negedge clk);
    data = csr_rdata;
  endtask

  task automatic drive_irq(input irq_vec_t lines);
    @(posedge clk);
    irq <= lines;
  endtask

  task automatic wait_reset_release();
    int n;
    for (n = 0; n < RESET_TIMEOUT; n++) begin
      @(posedge clk);
      if (arst_n) begin
        break;
      end
    end
    if (n == RESET_TIMEOUT) begin
      report_timeout("reset release");
    end
  endtask

  // Returns at the negedge where the acknowledge is seen
  task automatic wait_for_ack();
    int n;
    for (n = 0; n < ACK_TIMEOUT; n++) begin
      @(negedge clk);
      if (irq_ack) begin
        break;
      end
    end
    if (n == ACK_TIMEOUT) begin
      report_timeout("interrupt acknowledge");
    end
  endtask

  task automatic wait_for_sleep(input logic level, input bit check_no_ack);
    int n;
    for (n = 0; n < SLEEP_TIMEOUT; n++) begin
      @(negedge clk);
      if (check_no_ack) begin
        compare_level("no acknowledge during wake-up", irq_ack, 1'b0);
      end
      if (core_sleep === level) begin
        break;
      end
    end
    if (n == SLEEP_TIMEOUT) begin
      report_timeout("core sleep level change");
    end
  endtask

  task automatic expect_no_ack(input int cycles);
    for (int n = 0; n < cycles; n++) begin
      @(negedge clk);
      compare_level("acknowledge while masked", irq_ack, 1'b0);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  task automatic reset_boot_test();
    csr_data_t first;
    csr_data_t second;
    wait_reset_release();
    @(negedge clk);
    compare_level("irq_ack_o after reset", irq_ack, 1'b0);
    compare_level("core_sleep_o after reset", core_sleep, 1'b0);
    // Counter frozen in boot wait
    csr_read(CSR_MCYCLE, first);
    compare_csr("mcycle before fetch enable", first, '0);
    csr_read(CSR_MCYCLE, second);
    compare_csr("mcycle still zero", second, '0);
    csr_read(CSR_MCYCLEH, first);
    compare_csr("mcycleh after reset", first, '0);
    @(posedge clk);
    fetch_enable <= 1'b1;
    repeat (3) @(posedge clk);
    csr_read(CSR_MCYCLE, first);
    csr_read(CSR_MCYCLE, second);
    if (!(first > 0) || !(second > first)) begin
      $display("FAILED at %0d ns: mcycle not advancing, reads %0d then %0d",
               $time, first, second);
      abort_run();
    end
  endtask

  task automatic csr_access_test();
    csr_data_t w;
    csr_data_t r;
    csr_data_t mie_val;
    mie_val = '0;
    for (int i = 0; i < 4; i++) begin
      w = random_word();
      csr_write(CSR_MIE, w);
      csr_read(CSR_MIE, r);
      mie_val = w & IRQ_MASK;
      compare_csr("mie readback", r, mie_val);
    end
    // Only the global enable survives
    csr_write(CSR_MSTATUS, 32'hFFFF_FFFF);
    csr_read(CSR_MSTATUS, r);
    compare_csr("mstatus all ones", r, 32'h0000_0008);
    csr_write(CSR_MSTATUS, 32'h0);
    csr_read(CSR_MSTATUS, r);
    compare_csr("mstatus cleared", r, 32'h0);
    // mip is read-only
    csr_write(CSR_MIP, random_word());
    csr_read(CSR_MIP, r);
    compare_csr("mip after write", r, 32'h0);
    csr_write(12'h7C0, random_word());
    csr_read(12'h7C0, r);
    compare_csr("unknown address", r, 32'h0);
    csr_read(CSR_MIE, r);
    compare_csr("mie after ignored writes", r, mie_val);
  endtask

  task automatic pending_view_test();
    irq_vec_t  lines;
    csr_data_t r;
    csr_write(CSR_MIE, 32'h0);
    csr_write(CSR_MSTATUS, 32'h0);
    for (int i = 0; i < 4; i++) begin
      lines = random_word();
      drive_irq(lines);
      // Poll until the registered view matches
      for (int n = 0; n < MIP_TIMEOUT; n++) begin
        csr_read(CSR_MIP, r);
        if (r == (lines & IRQ_MASK)) begin
          break;
        end
      end
      compare_csr("mip pending view", r, lines & IRQ_MASK);
    end
    drive_irq('0);
  endtask

  task automatic irq_accept_test();
    irq_vec_t  mie_val;
    irq_vec_t  lines;
    irq_id_t   exp_id;
    csr_data_t r;
    for (int i = 0; i < 8; i++) begin
      mie_val = random_word() & IRQ_MASK;
      lines   = random_word();
      // Odd rounds exercise the three standard lines
      if (i % 2 == 1) begin
        mie_val = mie_val & LOW_LINES;
        lines   = lines & LOW_LINES;
      end
      if (mie_val == '0) begin
        mie_val = 32'h0000_0080;
      end
      if ((lines & mie_val) == '0) begin
        lines = lines | mie_val;
      end
      exp_id = expected_id(lines & mie_val & IRQ_MASK);
      csr_write(CSR_MIE, mie_val);
      drive_irq(lines);
      // mip settles one cycle after sampling
      repeat (2) @(posedge clk);
      csr_write(CSR_MSTATUS, 32'h0000_0008);
      wait_for_ack();
      compare_irq_id("winning interrupt id", irq_id, exp_id);
      @(negedge clk);
      compare_level("acknowledge lasts one cycle", irq_ack, 1'b0);
      csr_read(CSR_MSTATUS, r);
      compare_csr("mstatus after acknowledge", r, 32'h0);
      drive_irq('0);
    end
  endtask

  task automatic masked_irq_test();
    // Line enabled but global enable clear
    csr_write(CSR_MSTATUS, 32'h0);
    csr_write(CSR_MIE, 32'h0000_0800);
    drive_irq(32'h0000_0800);
    expect_no_ack(QUIET_CYCLES);
    // Global enable set but pending lines not in mie
    drive_irq(32'h0001_0008);
    csr_write(CSR_MIE, 32'h0000_0080);
    csr_write(CSR_MSTATUS, 32'h0000_0008);
    expect_no_ack(QUIET_CYCLES);
    csr_write(CSR_MSTATUS, 32'h0);
    csr_write(CSR_MIE, 32'h0);
    drive_irq('0);
  endtask

  task automatic sleep_wake_test();
    irq_vec_t  mie_val;
    irq_vec_t  lines;
    csr_data_t first;
    csr_data_t second;
    mie_val = (random_word() & IRQ_MASK) | 32'h0000_0080;
    lines   = 32'h0000_0080 | (random_word() & mie_val);
    csr_write(CSR_MSTATUS, 32'h0);
    csr_write(CSR_MIE, mie_val);
    @(posedge clk);
    wfi <= 1'b1;
    @(posedge clk);
    wfi <= 1'b0;
    wait_for_sleep(1'b1, 1'b0);
    // Counter halts while asleep
    csr_read(CSR_MCYCLE, first);
    csr_read(CSR_MCYCLE, second);
    compare_csr("mcycle frozen in sleep", second, first);
    // Wake-up ignores the global enable
    drive_irq(lines);
    wait_for_sleep(1'b0, 1'b1);
    expect_no_ack(5);
    csr_write(CSR_MSTATUS, 32'h0000_0008);
    wait_for_ack();
    compare_irq_id("id after wake-up", irq_id, expected_id(lines & mie_val & IRQ_MASK));
    drive_irq('0);
    csr_read(CSR_MSTATUS, first);
    compare_csr("mstatus after wake-up acknowledge", first, 32'h0);
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    fetch_enable = 1'b0;
    wfi          = 1'b0;
    irq          = '0;
    csr_we       = 1'b0;
    csr_addr     = '0;
    csr_wdata    = '0;
    lfsr_state   = 32'hf224_a5d1;

    reset_boot_test();
    csr_access_test();
    pending_view_test();
    irq_accept_test();
    masked_irq_test();
    sleep_wake_test();

    $display("test passed");
    $finish;
  end

endmodule

//--- dv/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic arst_n_o
);

  // 100 ns period
  localparam time HALF_PERIOD = 50ns;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // Reset held for 10 cycles, released away from the rising edge
  initial begin
    arst_n_o = 1'b0;
    repeat (10) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o <= 1'b1;
  end

endmodule

//--- source/core_ctrl_top.sv
`timescale 1ns/1ps

module core_ctrl_top (
  input  logic                     clk_i,
  input  logic                     arst_n_i,

  // Core control
  input  logic                     fetch_enable_i,
  input  logic                     wfi_i,

  // Interrupt lines
  input  core_ctrl_pkg::irq_vec_t  irq_i,

  // CSR access port
  input  logic                     csr_we_i,
  input  core_ctrl_pkg::csr_addr_t csr_addr_i,
  input  core_ctrl_pkg::csr_data_t csr_wdata_i,
  output core_ctrl_pkg::csr_data_t csr_rdata_o,

  // Interrupt acknowledge and status
  output logic                     irq_ack_o,
  output core_ctrl_pkg::irq_id_t   irq_id_o,
  output logic                     core_sleep_o
);

  import core_ctrl_pkg::*;

  // Interrupt controller to FSM
  logic     irq_req;
  logic     irq_wu;
  irq_id_t  irq_id_winner;

  // Between interrupt controller and CSRs
  irq_vec_t mip;
  irq_vec_t mie;
  logic     mstatus_mie;

  // Counter path
  logic     count_en;
  mcycle_t  mcycle;

  ////////////////////////////////////////////////////////////
  // Interrupt controller
  ////////////////////////////////////////////////////////////

  int_controller int_controller_i (
    .clk_i         ( clk_i         ),
    .arst_n_i      ( arst_n_i      ),
    .irq_i         ( irq_i         ),
    .mie_i         ( mie           ),
    .mstatus_mie_i ( mstatus_mie   ),
    .mip_o         ( mip           ),
    .irq_req_o     ( irq_req       ),
    .irq_wu_o      ( irq_wu        ),
    .irq_id_o      ( irq_id_winner )
  );

  ////////////////////////////////////////////////////////////
  // CSRs and cycle counter
  ////////////////////////////////////////////////////////////

  // Acknowledge doubles as the taken pulse
  csr_regs csr_regs_i (
    .clk_i         ( clk_i       ),
    .arst_n_i      ( arst_n_i    ),
    .csr_we_i      ( csr_we_i    ),
    .csr_addr_i    ( csr_addr_i  ),
    .csr_wdata_i   ( csr_wdata_i ),
    .csr_rdata_o   ( csr_rdata_o ),
    .irq_taken_i   ( irq_ack_o   ),
    .mip_i         ( mip         ),
    .mcycle_i      ( mcycle      ),
    .mie_o         ( mie         ),
    .mstatus_mie_o ( mstatus_mie )
  );

  cycle_counter cycle_counter_i (
    .clk_i      ( clk_i    ),
    .arst_n_i   ( arst_n_i ),
    .count_en_i ( count_en ),
    .mcycle_o   ( mcycle   )
  );

  ////////////////////////////////////////////////////////////
  // Controller
  ////////////////////////////////////////////////////////////

  ctrl_fsm ctrl_fsm_i (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .fetch_enable_i ( fetch_enable_i ),
    .wfi_i          ( wfi_i          ),
    .irq_req_i      ( irq_req        ),
    .irq_wu_i       ( irq_wu         ),
    .irq_id_i       ( irq_id_winner  ),
    .irq_ack_o      ( irq_ack_o      ),
    .irq_id_o       ( irq_id_o       ),
    .core_sleep_o   ( core_sleep_o   ),
    .count_en_o     ( count_en       )
  );

endmodule

//--- source/ctrl_fsm.sv
`timescale 1ns/1ps

module ctrl_fsm (
  input  logic                   clk_i,
  input  logic                   arst_n_i,

  // Start of execution after boot
  input  logic                   fetch_enable_i,

  // Decoded WFI, one-cycle strobe
  input  logic                   wfi_i,

  // From interrupt controller
  input  logic                   irq_req_i,
  input  logic                   irq_wu_i,
  input  core_ctrl_pkg::irq_id_t irq_id_i,

  // Interrupt acknowledge
  output logic                   irq_ack_o,
  output core_ctrl_pkg::irq_id_t irq_id_o,

  // Status
  output logic                   core_sleep_o,
  output logic                   count_en_o
);

  import core_ctrl_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  irq_id_t     irq_id_q;

  ////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      // Wait for fetch enable, ignored afterwards
      CTRL_BOOT_WAIT: begin
        if (fetch_enable_i) begin
          state_d = CTRL_RUN;
        end
      end
      // WFI wins over a pending request
      CTRL_RUN: begin
        if (wfi_i) begin
          state_d = CTRL_SLEEP;
        end else if (irq_req_i) begin
          state_d = CTRL_IRQ_TAKEN;
        end
      end
      // Single acknowledge cycle
      CTRL_IRQ_TAKEN: begin
        state_d = CTRL_RUN;
      end
      // Wake on any enabled pending line
      CTRL_SLEEP: begin
        if (irq_wu_i) begin
          state_d = CTRL_RUN;
        end
      end
      default: begin
        state_d = CTRL_BOOT_WAIT;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= CTRL_BOOT_WAIT;
    end else begin
      state_q <= state_d;
    end
  end

  // Capture the winner on entry into the acknowledge state
  always_ff @(posedge clk_i) begin
    if ((state_q == CTRL_RUN) && (state_d == CTRL_IRQ_TAKEN)) begin
      irq_id_q <= irq_id_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////

  assign irq_ack_o    = (state_q == CTRL_IRQ_TAKEN);
  assign irq_id_o     = irq_id_q;
  assign core_sleep_o = (state_q == CTRL_SLEEP);

  // Count only while running or taking an interrupt
  assign count_en_o   = (state_q == CTRL_RUN) || (state_q == CTRL_IRQ_TAKEN);

endmodule

//--- source/cycle_counter.sv
`timescale 1ns/1ps

module cycle_counter (
  input  logic                   clk_i,
  input  logic                   arst_n_i,

  // High while the core is active
  input  logic                   count_en_i,

  // Machine cycle count
  output core_ctrl_pkg::mcycle_t mcycle_o
);

  import core_ctrl_pkg::*;

  mcycle_t mcycle_q;

  // Halts in boot wait and in sleep
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mcycle_q <= '0;
    end else if (count_en_i) begin
      mcycle_q <= mcycle_q + mcycle_t'(1);
    end
  end

  assign mcycle_o = mcycle_q;

endmodule

//--- source/csr_regs.sv
`timescale 1ns/1ps

module csr_regs (
  input  logic                     clk_i,
  input  logic                     arst_n_i,

  // CSR access port
  input  logic                     csr_we_i,
  input  core_ctrl_pkg::csr_addr_t csr_addr_i,
  input  core_ctrl_pkg::csr_data_t csr_wdata_i,
  output core_ctrl_pkg::csr_data_t csr_rdata_o,

  // Acknowledge from the controller
  input  logic                     irq_taken_i,

  // Status sources
  input  core_ctrl_pkg::irq_vec_t  mip_i,
  input  core_ctrl_pkg::mcycle_t   mcycle_i,

  // To interrupt controller
  output core_ctrl_pkg::irq_vec_t  mie_o,
  output logic                     mstatus_mie_o
);

  import core_ctrl_pkg::*;

  irq_vec_t mie_q;
  logic     mstatus_mie_q;

  ////////////////////////////////////////////////////////////
  // Writes
  ////////////////////////////////////////////////////////////

  // Only supported lines can be enabled
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mie_q <= '0;
    end else if (csr_we_i && (csr_addr_i == CSR_MIE)) begin
      mie_q <= csr_wdata_i & IRQ_MASK;
    end
  end

  // Taking an interrupt clears MIE over a software write
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mstatus_mie_q <= 1'b0;
    end else if (irq_taken_i) begin
      mstatus_mie_q <= 1'b0;
    end else if (csr_we_i && (csr_addr_i == CSR_MSTATUS)) begin
      mstatus_mie_q <= csr_wdata_i[MSTATUS_MIE_BIT];
    end
  end

  assign mie_o         = mie_q;
  assign mstatus_mie_o = mstatus_mie_q;

  ////////////////////////////////////////////////////////////
  // Read mux
  ////////////////////////////////////////////////////////////

  // Same-cycle read of the addressed CSR
  always_comb begin
    csr_rdata_o = '0;
    case (csr_addr_i)
      CSR_MSTATUS: begin
        csr_rdata_o[MSTATUS_MIE_BIT] = mstatus_mie_q;
      end
      CSR_MIE: begin
        csr_rdata_o = mie_q;
      end
      // mip is masked at the source
      CSR_MIP: begin
        csr_rdata_o = mip_i;
      end
      CSR_MCYCLE: begin
        csr_rdata_o = mcycle_i[CSR_DATA_W-1:0];
      end
      CSR_MCYCLEH: begin
        csr_rdata_o = mcycle_i[MCYCLE_W-1:CSR_DATA_W];
      end
      // Unknown addresses read zero
      default: begin
        csr_rdata_o = '0;
      end
    endcase
  end

endmodule

//--- source/int_controller.sv
`timescale 1ns/1ps

module int_controller (
  input  logic                    clk_i,
  input  logic                    arst_n_i,

  // External interrupt lines, level sensitive
  input  core_ctrl_pkg::irq_vec_t irq_i,

  // From CSR block
  input  core_ctrl_pkg::irq_vec_t mie_i,
  input  logic                    mstatus_mie_i,

  // To CSR block
  output core_ctrl_pkg::irq_vec_t mip_o,

  // To controller FSM
  output logic                    irq_req_o,
  output logic                    irq_wu_o,
  output core_ctrl_pkg::irq_id_t  irq_id_o
);

  import core_ctrl_pkg::*;

  irq_vec_t mip_q;
  irq_vec_t irq_pending;

  // Sample the lines, unsupported ones never reach mip
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mip_q <= '0;
    end else begin
      mip_q <= irq_i & IRQ_MASK;
    end
  end

  assign mip_o       = mip_q;

  // Pending and locally enabled
  assign irq_pending = mip_q & mie_i;

  // Wake-up ignores the global enable
  assign irq_wu_o    = |irq_pending;
  assign irq_req_o   = irq_wu_o & mstatus_mie_i;

  // Fixed priority, lowest first so the last hit wins
  // Order is timer, software, external, then fast lines
  always_comb begin
    irq_id_o = '0;
    if (irq_pending[IRQ_ID_MTI]) begin
      irq_id_o = IRQ_ID_MTI;
    end
    if (irq_pending[IRQ_ID_MSI]) begin
      irq_id_o = IRQ_ID_MSI;
    end
    if (irq_pending[IRQ_ID_MEI]) begin
      irq_id_o = IRQ_ID_MEI;
    end
    // Higher fast index wins
    for (int i = IRQ_FAST_LO; i <= IRQ_FAST_HI; i++) begin
      if (irq_pending[i]) begin
        irq_id_o = irq_id_t'(i);
      end
    end
  end

endmodule

//--- source/core_ctrl_pkg.sv
package core_ctrl_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  localparam int CSR_ADDR_W = 12;
  localparam int CSR_DATA_W = 32;
  localparam int IRQ_W      = 32;
  localparam int IRQ_ID_W   = 5;
  localparam int MCYCLE_W   = 64;

  // Machine CSR address and data word
  typedef logic [CSR_ADDR_W-1:0] csr_addr_t;
  typedef logic [CSR_DATA_W-1:0] csr_data_t;

  // One bit per interrupt line, as in mie and mip
  typedef logic [IRQ_W-1:0]      irq_vec_t;
  typedef logic [IRQ_ID_W-1:0]   irq_id_t;

  // Full machine cycle count
  typedef logic [MCYCLE_W-1:0]   mcycle_t;

  ////////////////////////////////////////////////////////////
  // CSR map
  ////////////////////////////////////////////////////////////

  localparam csr_addr_t CSR_MSTATUS = 12'h300;
  localparam csr_addr_t CSR_MIE     = 12'h304;
  localparam csr_addr_t CSR_MIP     = 12'h344;
  localparam csr_addr_t CSR_MCYCLE  = 12'hB00;
  localparam csr_addr_t CSR_MCYCLEH = 12'hB80;

  // Global machine interrupt enable inside mstatus
  localparam int MSTATUS_MIE_BIT = 3;

  ////////////////////////////////////////////////////////////
  // Interrupt lines
  ////////////////////////////////////////////////////////////

  // Software, timer, external and the 16 fast lines
  localparam irq_vec_t IRQ_MASK = 32'hFFFF_0888;

  localparam irq_id_t IRQ_ID_MSI = 5'd3;
  localparam irq_id_t IRQ_ID_MTI = 5'd7;
  localparam irq_id_t IRQ_ID_MEI = 5'd11;

  // Range of the fast lines
  localparam int IRQ_FAST_LO = 16;
  localparam int IRQ_FAST_HI = 31;

  // Controller states
  typedef enum logic [1:0] {
    CTRL_BOOT_WAIT = 2'd0,
    CTRL_RUN       = 2'd1,
    CTRL_IRQ_TAKEN = 2'd2,
    CTRL_SLEEP     = 2'd3
  } ctrl_state_e;

endpackage
